/* list.f */
rtl/eth_dma_pkg.sv
rtl/bd_table.sv
rtl/tx_dma_engine.sv
rtl/rx_dma_engine.sv
rtl/eth_dma_top.sv
verif/eth_dma_props.sv
verif/eth_dma_tb.sv

/* rtl/bd_table.sv */
////////////////////////////////////////
// Engine write wins over a CPU write to the same word
////////////////////////////////////////
`timescale 1ns/1ps

module bd_table import eth_dma_pkg::*; (
   input  logic                clk_i,
   input  logic                arst_i,
   input  logic                cpu_bd_wen_i,
   input  logic [BD_IDX_W-1:0] cpu_bd_addr_i,
   input  bd_ctrl_t            cpu_bd_wdata_i,
   output bd_ctrl_t            cpu_bd_rdata_o,
   input  logic                tx_req_i,
   input  logic [BD_IDX_W-1:0] tx_idx_i,
   input  logic                tx_wen_i,
   input  bd_ctrl_t            tx_wdata_i,
   output logic                tx_gnt_o,
   input  logic                rx_req_i,
   input  logic [BD_IDX_W-1:0] rx_idx_i,
   input  logic                rx_wen_i,
   input  bd_ctrl_t            rx_wdata_i,
   output logic                rx_gnt_o,
   output bd_ctrl_t            bd_rdata_o
);

   bd_ctrl_t            mem [BD_NUM];
   logic                last_rx_q;
   logic [BD_IDX_W-1:0] eng_idx;
   logic                eng_wen;
   bd_ctrl_t            eng_wdata;

   // Round robin between the two engines
   assign tx_gnt_o = tx_req_i && (!rx_req_i || last_rx_q);
   assign rx_gnt_o = rx_req_i && !tx_gnt_o;

   assign eng_idx   = tx_gnt_o ? tx_idx_i : rx_idx_i;
   assign eng_wen   = (tx_gnt_o && tx_wen_i) || (rx_gnt_o && rx_wen_i);
   assign eng_wdata = tx_gnt_o ? tx_wdata_i : rx_wdata_i;

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         last_rx_q <= 1'b1;
      end else if (tx_gnt_o) begin
         last_rx_q <= 1'b0;
      end else if (rx_gnt_o) begin
         last_rx_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (cpu_bd_wen_i) begin
         mem[cpu_bd_addr_i] <= cpu_bd_wdata_i;
      end
      // Later assignment takes priority
      if (eng_wen) begin
         mem[eng_idx] <= eng_wdata;
      end
      cpu_bd_rdata_o <= mem[cpu_bd_addr_i];
      bd_rdata_o     <= mem[eng_idx];
   end

endmodule

/* rtl/eth_dma_pkg.sv */
////////////////////////////////////////
// Frame lengths above 2047 bytes are not supported
// Descriptor sizes are fixed here
////////////////////////////////////////
package eth_dma_pkg;

   localparam int BUFFER_W     = 11;
   localparam int NBYTES_W     = 11;
   localparam int BD_NUM       = 16;
   localparam int BD_IDX_W     = 4;

   // Ethernet framing
   localparam int         PREAMBLE_LEN  = 7;
   localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
   localparam logic [7:0] SFD_BYTE      = 8'hD5;
   localparam int         PRE_FRAME_LEN = PREAMBLE_LEN + 1;

   // FSM encodings
   localparam int                 STATE_W  = 3;
   localparam logic [STATE_W-1:0] TX_FILL  = 3'd0;
   localparam logic [STATE_W-1:0] TX_REQ   = 3'd1;
   localparam logic [STATE_W-1:0] TX_CHECK = 3'd2;
   localparam logic [STATE_W-1:0] TX_WAIT  = 3'd3;
   localparam logic [STATE_W-1:0] TX_COPY  = 3'd4;
   localparam logic [STATE_W-1:0] TX_SEND  = 3'd5;
   localparam logic [STATE_W-1:0] TX_WB    = 3'd6;
   localparam logic [STATE_W-1:0] RX_REQ   = 3'd0;
   localparam logic [STATE_W-1:0] RX_CHECK = 3'd1;
   localparam logic [STATE_W-1:0] RX_WAIT  = 3'd2;
   localparam logic [STATE_W-1:0] RX_READ  = 3'd3;
   localparam logic [STATE_W-1:0] RX_ACK   = 3'd4;
   localparam logic [STATE_W-1:0] RX_WB    = 3'd5;

   typedef struct packed {
      logic [15:0] length;
      logic        ready;
      logic        irq;
      logic        wrap;
      logic        rsvd_12;
      logic        crc_en;
      logic [10:0] rsvd_10_0;
   } bd_tx_t;

   typedef struct packed {
      logic [15:0] length;
      logic        ready;
      logic        irq;
      logic        wrap;
      logic [10:0] rsvd_12_2;
      logic        crc_err;
      logic        rsvd_0;
   } bd_rx_t;

   // One control word, read per engine
   typedef union packed {
      bd_tx_t tx;
      bd_rx_t rx;
   } bd_ctrl_t;

endpackage

/* rtl/eth_dma_top.sv */
////////////////////////////////////////
// Buffers live outside this block
////////////////////////////////////////
`timescale 1ns/1ps

module eth_dma_top import eth_dma_pkg::*; (
   input  logic                clk_i,
   input  logic                arst_i,
   input  logic                tx_en_i,
   input  logic                rx_en_i,
   input  logic [BD_IDX_W-1:0] tx_bd_num_i,
   input  logic                cpu_bd_wen_i,
   input  logic [BD_IDX_W-1:0] cpu_bd_addr_i,
   input  bd_ctrl_t            cpu_bd_wdata_i,
   output bd_ctrl_t            cpu_bd_rdata_o,
   output logic                eth_data_wr_wen_o,
   output logic [BUFFER_W-1:0] eth_data_wr_addr_o,
   output logic [7:0]          eth_data_wr_wdata_o,
   input  logic                tx_ready_i,
   output logic                send_o,
   output logic [NBYTES_W-1:0] tx_nbytes_o,
   output logic                crc_en_o,
   output logic [BUFFER_W-1:0] eth_data_rd_addr_o,
   input  logic [7:0]          eth_data_rd_rdata_i,
   input  logic                rx_data_rcvd_i,
   input  logic                crc_err_i,
   input  logic [NBYTES_W-1:0] rx_nbytes_i,
   output logic                rcv_ack_o,
   output logic                tx_irq_o,
   output logic                rx_irq_o,
   output logic [BD_IDX_W-1:0] tx_bd_cnt_o,
   output logic [NBYTES_W-1:0] tx_word_cnt_o,
   output logic                tx_frame_word_ready_o,
   input  logic                tx_frame_word_wen_i,
   input  logic [7:0]          tx_frame_word_wdata_i,
   output logic [BD_IDX_W-1:0] rx_bd_cnt_o,
   output logic [NBYTES_W-1:0] rx_word_cnt_o,
   output logic                rx_frame_word_ready_o,
   input  logic                rx_frame_word_ren_i,
   output logic [7:0]          rx_frame_word_rdata_o,
   output logic                rx_frame_word_rvalid_o
);

   // Engine side of the descriptor table
   logic                tx_bd_req;
   logic [BD_IDX_W-1:0] tx_bd_idx;
   logic                tx_bd_wen;
   bd_ctrl_t            tx_bd_wdata;
   logic                tx_bd_gnt;
   logic                rx_bd_req;
   logic [BD_IDX_W-1:0] rx_bd_idx;
   logic                rx_bd_wen;
   bd_ctrl_t            rx_bd_wdata;
   logic                rx_bd_gnt;
   bd_ctrl_t            bd_rdata;

   bd_table u_bd_table (
      .*,
      .tx_req_i   (tx_bd_req),
      .tx_idx_i   (tx_bd_idx),
      .tx_wen_i   (tx_bd_wen),
      .tx_wdata_i (tx_bd_wdata),
      .tx_gnt_o   (tx_bd_gnt),
      .rx_req_i   (rx_bd_req),
      .rx_idx_i   (rx_bd_idx),
      .rx_wen_i   (rx_bd_wen),
      .rx_wdata_i (rx_bd_wdata),
      .rx_gnt_o   (rx_bd_gnt),
      .bd_rdata_o (bd_rdata)
   );

   tx_dma_engine u_tx_dma_engine (
      .*,
      .bd_req_o   (tx_bd_req),
      .bd_idx_o   (tx_bd_idx),
      .bd_wen_o   (tx_bd_wen),
      .bd_wdata_o (tx_bd_wdata),
      .bd_gnt_i   (tx_bd_gnt),
      .bd_rdata_i (bd_rdata)
   );

   rx_dma_engine u_rx_dma_engine (
      .*,
      .bd_req_o   (rx_bd_req),
      .bd_idx_o   (rx_bd_idx),
      .bd_wen_o   (rx_bd_wen),
      .bd_wdata_o (rx_bd_wdata),
      .bd_gnt_i   (rx_bd_gnt),
      .bd_rdata_i (bd_rdata)
   );

endmodule

/* rtl/rx_dma_engine.sv */
////////////////////////////////////////
// Receive buffer read has one cycle of latency
// tx_bd_num_i should stay stable while receiving
////////////////////////////////////////
`timescale 1ns/1ps

module rx_dma_engine import eth_dma_pkg::*; (
   input  logic                clk_i,
   input  logic                arst_i,
   input  logic                rx_en_i,
   input  logic [BD_IDX_W-1:0] tx_bd_num_i,
   output logic                bd_req_o,
   output logic [BD_IDX_W-1:0] bd_idx_o,
   output logic                bd_wen_o,
   output bd_ctrl_t            bd_wdata_o,
   input  logic                bd_gnt_i,
   input  bd_ctrl_t            bd_rdata_i,
   output logic [BUFFER_W-1:0] eth_data_rd_addr_o,
   input  logic [7:0]          eth_data_rd_rdata_i,
   input  logic                rx_data_rcvd_i,
   input  logic                crc_err_i,
   input  logic [NBYTES_W-1:0] rx_nbytes_i,
   output logic                rcv_ack_o,
   output logic                rx_irq_o,
   output logic [BD_IDX_W-1:0] rx_bd_cnt_o,
   output logic [NBYTES_W-1:0] rx_word_cnt_o,
   output logic                rx_frame_word_ready_o,
   input  logic                rx_frame_word_ren_i,
   output logic [7:0]          rx_frame_word_rdata_o,
   output logic                rx_frame_word_rvalid_o
);

   logic [STATE_W-1:0]  state_q;
   logic [NBYTES_W-1:0] cnt_q;
   logic [BD_IDX_W-1:0] bd_num_q;
   logic [BD_IDX_W-1:0] bd_num_next;
   bd_ctrl_t            desc_q;
   logic                read_end;
   logic                rd_accept;

   assign read_end  = (state_q == RX_READ) && (cnt_q == rx_nbytes_i);
   assign rd_accept = rx_frame_word_ready_o && rx_frame_word_ren_i;

   assign rx_frame_word_ready_o = (state_q == RX_READ) && !read_end;
   assign rx_bd_cnt_o           = bd_num_q;
   assign rx_word_cnt_o         = cnt_q;

   // Look one byte ahead so the next strobe sees its data
   assign eth_data_rd_addr_o = rd_accept ? cnt_q + 1'b1 : cnt_q;

   assign bd_req_o   = (state_q == RX_REQ) || (state_q == RX_WB);
   assign bd_idx_o   = bd_num_q;
   assign bd_wen_o   = (state_q == RX_WB);
   assign bd_wdata_o = desc_q;
   assign rx_irq_o   = (state_q == RX_WB) && bd_gnt_i && desc_q.rx.irq;

   assign bd_num_next = (desc_q.rx.wrap || bd_num_q == BD_IDX_W'(BD_NUM - 1)) ?
                        tx_bd_num_i : bd_num_q + 1'b1;

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q                <= RX_REQ;
         cnt_q                  <= '0;
         bd_num_q               <= tx_bd_num_i;
         rcv_ack_o              <= 1'b0;
         rx_frame_word_rvalid_o <= 1'b0;
      end else begin
         rx_frame_word_rvalid_o <= rd_accept;
         case (state_q)
            RX_REQ: begin
               if (bd_gnt_i) begin
                  state_q <= RX_CHECK;
               end
            end
            RX_CHECK: begin
               cnt_q   <= '0;
               state_q <= (bd_rdata_i.rx.ready && rx_en_i) ? RX_WAIT : RX_REQ;
            end
            RX_WAIT: begin
               if (rx_data_rcvd_i) begin
                  state_q <= RX_READ;
               end
            end
            RX_READ: begin
               if (read_end) begin
                  rcv_ack_o <= 1'b1;
                  state_q   <= RX_ACK;
               end else if (rd_accept) begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            RX_ACK: begin
               if (!rx_data_rcvd_i) begin
                  rcv_ack_o <= 1'b0;
                  state_q   <= RX_WB;
               end
            end
            RX_WB: begin
               if (bd_gnt_i) begin
                  bd_num_q <= bd_num_next;
                  state_q  <= RX_REQ;
               end
            end
            default: state_q <= RX_REQ;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_accept) begin
         rx_frame_word_rdata_o <= eth_data_rd_rdata_i;
      end
      if (state_q == RX_CHECK) begin
         desc_q <= bd_rdata_i;
      end
      // Receive status in the receive view of the word
      if (read_end) begin
         desc_q.rx.ready   <= 1'b0;
         desc_q.rx.crc_err <= crc_err_i;
         desc_q.rx.length  <= 16'(rx_nbytes_i);
      end
   end

endmodule

/* rtl/tx_dma_engine.sv */
////////////////////////////////////////
// Preamble and SFD are written once after reset
// Only the low 11 length bits are honoured
////////////////////////////////////////
`timescale 1ns/1ps

module tx_dma_engine import eth_dma_pkg::*; (
   input  logic                clk_i,
   input  logic                arst_i,
   input  logic                tx_en_i,
   output logic                bd_req_o,
   output logic [BD_IDX_W-1:0] bd_idx_o,
   output logic                bd_wen_o,
   output bd_ctrl_t            bd_wdata_o,
   input  logic                bd_gnt_i,
   input  bd_ctrl_t            bd_rdata_i,
   output logic                eth_data_wr_wen_o,
   output logic [BUFFER_W-1:0] eth_data_wr_addr_o,
   output logic [7:0]          eth_data_wr_wdata_o,
   input  logic                tx_ready_i,
   output logic                send_o,
   output logic [NBYTES_W-1:0] tx_nbytes_o,
   output logic                crc_en_o,
   output logic                tx_irq_o,
   output logic [BD_IDX_W-1:0] tx_bd_cnt_o,
   output logic [NBYTES_W-1:0] tx_word_cnt_o,
   output logic                tx_frame_word_ready_o,
   input  logic                tx_frame_word_wen_i,
   input  logic [7:0]          tx_frame_word_wdata_i
);

   logic [STATE_W-1:0]  state_q;
   logic [NBYTES_W-1:0] cnt_q;
   logic [BD_IDX_W-1:0] bd_num_q;
   logic [BD_IDX_W-1:0] bd_num_next;
   bd_ctrl_t            desc_q;
   logic                fill;
   logic                copy_end;
   logic                wr_accept;

   assign fill      = (state_q == TX_FILL);
   assign copy_end  = (state_q == TX_COPY) && (cnt_q == desc_q.tx.length[NBYTES_W-1:0]);
   assign wr_accept = (state_q == TX_COPY) && !copy_end && tx_frame_word_wen_i;

   // Buffer writes come from the fill or from the CPU
   assign eth_data_wr_wen_o   = fill || wr_accept;
   assign eth_data_wr_addr_o  = fill ? cnt_q : BUFFER_W'(PRE_FRAME_LEN) + cnt_q;
   assign eth_data_wr_wdata_o = !fill ? tx_frame_word_wdata_i :
                                (cnt_q == NBYTES_W'(PREAMBLE_LEN)) ? SFD_BYTE : PREAMBLE_BYTE;

   assign tx_frame_word_ready_o = (state_q == TX_COPY);
   assign tx_bd_cnt_o           = bd_num_q;
   assign tx_word_cnt_o         = cnt_q;

   assign bd_req_o   = (state_q == TX_REQ) || (state_q == TX_WB);
   assign bd_idx_o   = bd_num_q;
   assign bd_wen_o   = (state_q == TX_WB);
   assign bd_wdata_o = desc_q;
   assign tx_irq_o   = (state_q == TX_WB) && bd_gnt_i && desc_q.tx.irq;

   // Wrap bit or last entry returns to descriptor 0
   assign bd_num_next = (desc_q.tx.wrap || bd_num_q == BD_IDX_W'(BD_NUM - 1)) ?
                        '0 : bd_num_q + 1'b1;

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q  <= TX_FILL;
         cnt_q    <= '0;
         bd_num_q <= '0;
         send_o   <= 1'b0;
      end else begin
         case (state_q)
            TX_FILL: begin
               cnt_q <= cnt_q + 1'b1;
               if (cnt_q == NBYTES_W'(PRE_FRAME_LEN - 1)) begin
                  state_q <= TX_REQ;
               end
            end
            TX_REQ: begin
               if (bd_gnt_i) begin
                  state_q <= TX_CHECK;
               end
            end
            TX_CHECK: begin
               state_q <= (bd_rdata_i.tx.ready && tx_en_i) ? TX_WAIT : TX_REQ;
            end
            TX_WAIT: begin
               if (tx_ready_i) begin
                  cnt_q   <= '0;
                  state_q <= TX_COPY;
               end
            end
            TX_COPY: begin
               if (copy_end) begin
                  send_o  <= 1'b1;
                  state_q <= TX_SEND;
               end else if (wr_accept) begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            TX_SEND: begin
               // Front-end drops ready once it has taken the frame
               if (!tx_ready_i) begin
                  send_o  <= 1'b0;
                  state_q <= TX_WB;
               end
            end
            TX_WB: begin
               if (bd_gnt_i) begin
                  bd_num_q <= bd_num_next;
                  state_q  <= TX_REQ;
               end
            end
            default: state_q <= TX_REQ;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == TX_CHECK) begin
         desc_q <= bd_rdata_i;
      end
      if (copy_end) begin
         desc_q.tx.ready <= 1'b0;
         tx_nbytes_o     <= desc_q.tx.length[NBYTES_W-1:0] + NBYTES_W'(PRE_FRAME_LEN);
         crc_en_o        <= desc_q.tx.crc_en;
      end
   end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module eth_dma_tb -o sim_eth_dma
./obj_dir/sim_eth_dma > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test completed successfully$" sim.log; then
   exit 0
fi
exit 1

/* verif/eth_dma_props.sv */
////////////////////////////////////////
// Bound to eth_dma_top
////////////////////////////////////////
`timescale 1ns/1ps

module eth_dma_props (
   input logic clk_i,
   input logic arst_i,
   input logic tx_irq_o,
   input logic rx_irq_o,
   input logic send_o,
   input logic tx_frame_word_ready_o,
   input logic rx_frame_word_ready_o,
   input logic rx_frame_word_ren_i,
   input logic rx_frame_word_rvalid_o
);

   // Interrupts are single cycle pulses
   a_tx_irq_pulse: assert property (@(posedge clk_i) disable iff (arst_i)
      tx_irq_o |=> !tx_irq_o) else $error("tx_irq_o high for two cycles");

   a_rx_irq_pulse: assert property (@(posedge clk_i) disable iff (arst_i)
      rx_irq_o |=> !rx_irq_o) else $error("rx_irq_o high for two cycles");

   a_send_vs_copy: assert property (@(posedge clk_i) disable iff (arst_i)
      !(send_o && tx_frame_word_ready_o)) else $error("send_o during byte copy");

   a_rvalid: assert property (@(posedge clk_i) disable iff (arst_i)
      rx_frame_word_rvalid_o |-> $past(rx_frame_word_ready_o && rx_frame_word_ren_i))
      else $error("rx_frame_word_rvalid_o without a read strobe");

endmodule

/* verif/eth_dma_tb.sv */
////////////////////////////////////////
// Directed tests, one after another
// Receive descriptors start at index 8
////////////////////////////////////////
`timescale 1ns/1ps

module eth_dma_tb;

   // Far above the few hundred cycles that all directed tests take
   localparam int TIMEOUT_CYCLES = 20000;

   logic        clk_i;
   logic        arst_i;
   logic        tx_en_i;
   logic        rx_en_i;
   logic [3:0]  tx_bd_num_i;
   logic        cpu_bd_wen_i;
   logic [3:0]  cpu_bd_addr_i;
   logic [31:0] cpu_bd_wdata_i;
   logic [31:0] cpu_bd_rdata_o;
   logic        eth_data_wr_wen_o;
   logic [10:0] eth_data_wr_addr_o;
   logic [7:0]  eth_data_wr_wdata_o;
   logic        tx_ready_i;
   logic        send_o;
   logic [10:0] tx_nbytes_o;
   logic        crc_en_o;
   logic [10:0] eth_data_rd_addr_o;
   logic [7:0]  eth_data_rd_rdata_i;
   logic        rx_data_rcvd_i;
   logic        crc_err_i;
   logic [10:0] rx_nbytes_i;
   logic        rcv_ack_o;
   logic        tx_irq_o;
   logic        rx_irq_o;
   logic [3:0]  tx_bd_cnt_o;
   logic [10:0] tx_word_cnt_o;
   logic        tx_frame_word_ready_o;
   logic        tx_frame_word_wen_i;
   logic [7:0]  tx_frame_word_wdata_i;
   logic [3:0]  rx_bd_cnt_o;
   logic [10:0] rx_word_cnt_o;
   logic        rx_frame_word_ready_o;
   logic        rx_frame_word_ren_i;
   logic [7:0]  rx_frame_word_rdata_o;
   logic        rx_frame_word_rvalid_o;

   integer      seed = 32'h84a8_9dad;
   int          err_cnt;
   int          test_cnt;
   int          fail_cnt;
   int          cycles;
   int          tx_irq_cnt;
   int          rx_irq_cnt;
   logic [10:0] wr_addr_q[$];
   logic [7:0]  wr_data_q[$];
   logic [7:0]  rx_mem [2048];

   eth_dma_top u_eth_dma_top (.*);

   bind eth_dma_top eth_dma_props u_eth_dma_props (.*);

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   // Transmit buffer write log and receive buffer with one cycle read
   always @(posedge clk_i) begin
      if (!arst_i && eth_data_wr_wen_o) begin
         wr_addr_q.push_back(eth_data_wr_addr_o);
         wr_data_q.push_back(eth_data_wr_wdata_o);
      end
      eth_data_rd_rdata_i <= rx_mem[eth_data_rd_addr_o];
   end

   always @(posedge clk_i) begin
      if (!arst_i) begin
         tx_irq_cnt <= tx_irq_cnt + int'(tx_irq_o);
         rx_irq_cnt <= rx_irq_cnt + int'(rx_irq_o);
      end
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, DUT stopped responding", cycles);
         $display("Test failed");
         $finish;
      end
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic report(input string name, input int err_before);
      test_cnt++;
      if (err_cnt != err_before) begin
         fail_cnt++;
         $display("%s: FAIL", name);
      end else begin
         $display("%s: PASS", name);
      end
   endtask

   // Length in 31:16, ready 15, irq 14, wrap 13, crc_en 11
   function automatic logic [31:0] make_word(input int len, input bit irq, input bit wrap,
                                             input bit crc);
      return {16'(len), 1'b1, irq, wrap, 1'b0, crc, 11'd0};
   endfunction

   task automatic bd_write(input int idx, input logic [31:0] word);
      @(negedge clk_i);
      cpu_bd_wen_i   = 1'b1;
      cpu_bd_addr_i  = 4'(idx);
      cpu_bd_wdata_i = word;
      @(negedge clk_i);
      cpu_bd_wen_i = 1'b0;
   endtask

   task automatic bd_check(input int idx, input logic [31:0] exp);
      @(negedge clk_i);
      cpu_bd_addr_i = 4'(idx);
      @(negedge clk_i);
      check("cpu_bd_rdata_o", cpu_bd_rdata_o, exp);
   endtask

   task automatic idle_no_ready(input int n);
      repeat (n) begin
         @(negedge clk_i);
         if (tx_frame_word_ready_o) begin
            $display("Transmit copy started while it should be held off");
            err_cnt++;
         end
      end
   endtask

   task automatic tx_frame(input int idx, input int len, input bit crc);
      logic [7:0] bytes[$];
      int         base;
      tx_en_i = 1'b1;
      while (!tx_frame_word_ready_o) @(negedge clk_i);
      check("tx_bd_cnt_o", 32'(tx_bd_cnt_o), 32'(idx));
      base = wr_addr_q.size();
      for (int i = 0; i < len; i++) begin
         check("tx_word_cnt_o", 32'(tx_word_cnt_o), 32'(i));
         bytes.push_back(8'($random(seed)));
         tx_frame_word_wen_i   = 1'b1;
         tx_frame_word_wdata_i = bytes[i];
         @(negedge clk_i);
      end
      tx_frame_word_wen_i = 1'b0;
      @(negedge clk_i);
      check("send_o", 32'(send_o), 32'd1);
      check("tx_nbytes_o", 32'(tx_nbytes_o), 32'(len + 8));
      check("crc_en_o", 32'(crc_en_o), 32'(crc));
      tx_ready_i = 1'b0;
      @(negedge clk_i);
      check("send_o", 32'(send_o), 32'd0);
      tx_ready_i = 1'b1;
      for (int i = 0; i < len; i++) begin
         check("eth_data_wr_addr_o", 32'(wr_addr_q[base + i]), 32'(8 + i));
         check("eth_data_wr_wdata_o", 32'(wr_data_q[base + i]), 32'(bytes[i]));
      end
   endtask

   task automatic rx_frame(input int idx, input int n);
      bit pend;
      int i;
      for (int k = 0; k < n; k++) begin
         rx_mem[k] = 8'($random(seed));
      end
      rx_nbytes_i    = 11'(n);
      crc_err_i      = 1'b1;
      rx_data_rcvd_i = 1'b1;
      rx_en_i        = 1'b1;
      pend = 1'b0;
      i    = 0;
      while (i < n || pend) begin
         @(negedge clk_i);
         if (pend) begin
            check("rx_frame_word_rvalid_o", 32'(rx_frame_word_rvalid_o), 32'd1);
            check("rx_frame_word_rdata_o", 32'(rx_frame_word_rdata_o), 32'(rx_mem[i - 1]));
         end
         pend = 1'b0;
         rx_frame_word_ren_i = 1'b0;
         if (i < n && rx_frame_word_ready_o) begin
            if (i == 0) begin
               check("rx_bd_cnt_o", 32'(rx_bd_cnt_o), 32'(idx));
            end
            check("rx_word_cnt_o", 32'(rx_word_cnt_o), 32'(i));
            rx_frame_word_ren_i = 1'b1;
            pend = 1'b1;
            i++;
         end
      end
      @(negedge clk_i);
      check("rcv_ack_o", 32'(rcv_ack_o), 32'd1);
      rx_data_rcvd_i = 1'b0;
      @(negedge clk_i);
      check("rcv_ack_o", 32'(rcv_ack_o), 32'd0);
   endtask

   task automatic wait_irqs(input int tx_exp, input int rx_exp);
      while (tx_irq_cnt < tx_exp || rx_irq_cnt < rx_exp) @(negedge clk_i);
      repeat (10) @(negedge clk_i);
      check("tx_irq_o pulses", 32'(tx_irq_cnt), 32'(tx_exp));
      check("rx_irq_o pulses", 32'(rx_irq_cnt), 32'(rx_exp));
   endtask

   initial begin
      int e;
      int len;
      int len2;
      logic [31:0] w;
      logic [31:0] w2;
      arst_i = 1'b1;
      {tx_en_i, rx_en_i, cpu_bd_wen_i, tx_ready_i, rx_data_rcvd_i, crc_err_i} = '0;
      {tx_frame_word_wen_i, rx_frame_word_ren_i} = '0;
      tx_bd_num_i           = 4'd8;
      cpu_bd_addr_i         = '0;
      cpu_bd_wdata_i        = '0;
      tx_frame_word_wdata_i = '0;
      rx_nbytes_i           = '0;
      eth_data_rd_rdata_i   = '0;
      repeat (8) @(negedge clk_i);
      arst_i = 1'b0;

      e = err_cnt;
      while (wr_addr_q.size() < 8) @(negedge clk_i);
      for (int i = 0; i < 8; i++) begin
         check("eth_data_wr_addr_o", 32'(wr_addr_q[i]), 32'(i));
         check("eth_data_wr_wdata_o", 32'(wr_data_q[i]), (i == 7) ? 32'hD5 : 32'h55);
      end
      report("preamble", e);

      for (int i = 0; i < 16; i++) begin
         bd_write(i, 32'd0);
      end

      e = err_cnt;
      tx_ready_i = 1'b1;
      len = 1 + ($random(seed) & 31);
      w = make_word(len, 1'b1, 1'b0, 1'b1);
      bd_write(0, w);
      tx_frame(0, len, 1'b1);
      wait_irqs(1, 0);
      bd_check(0, w & ~32'h8000);
      report("tx frame", e);

      e = err_cnt;
      tx_en_i = 1'b1;
      idle_no_ready(50);
      tx_en_i = 1'b0;
      w = make_word(4, 1'b1, 1'b1, 1'b0);
      bd_write(1, w);
      idle_no_ready(50);
      tx_frame(1, 4, 1'b0);
      wait_irqs(2, 0);
      bd_check(1, w & ~32'h8000);
      w = make_word(3, 1'b0, 1'b0, 1'b0);
      bd_write(0, w);
      tx_frame(0, 3, 1'b0);
      repeat (10) @(negedge clk_i);
      bd_check(0, w & ~32'h8000);
      report("gating and wrap", e);

      e = err_cnt;
      w = make_word(0, 1'b1, 1'b0, 1'b0);
      bd_write(8, w);
      len = 1 + ($random(seed) & 31);
      rx_frame(8, len);
      wait_irqs(2, 1);
      bd_check(8, {16'(len), 1'b0, w[14:2], 1'b1, w[0]});
      report("rx frame", e);

      e = err_cnt;
      len  = 1 + ($random(seed) & 31);
      len2 = 1 + ($random(seed) & 31);
      w  = make_word(len, 1'b1, 1'b0, 1'b1);
      w2 = make_word(0, 1'b1, 1'b0, 1'b0);
      bd_write(1, w);
      bd_write(9, w2);
      fork
         tx_frame(1, len, 1'b1);
         rx_frame(9, len2);
      join
      wait_irqs(3, 2);
      bd_check(1, w & ~32'h8000);
      bd_check(9, {16'(len2), 1'b0, w2[14:2], 1'b1, w2[0]});
      report("concurrent frames", e);

      $display("Tests run %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
